/* design/dac_spi_master.sv */
`timescale 1ns/100ps

module dac_spi_master #(
  parameter int spi_clk_div = 2 // clk cycles per sclk half period
) (
  input  logic                     clk,
  input  logic                     mems_soft_reset,
  input  logic                     start,
  input  mems_scan_pkg::dac_word_u word,
  output logic                     busy,
  output logic                     sclk,
  output logic                     mosi,
  output logic                     cs_n
);
  import mems_scan_pkg::*;

  localparam int div_w = (spi_clk_div > 1) ? $clog2(spi_clk_div) : 1;
  localparam int bit_w = $clog2(dac_word_bits);

  logic [dac_word_bits-2:0] shift_q;   // bits still to send, msb already on mosi
  logic [div_w-1:0]         div_cnt;
  logic [bit_w-1:0]         bit_cnt;   // falling edges seen
  logic                     tail;      // sclk finished, closing cs
  logic                     half_done;

  assign half_done = (div_cnt == div_w'(spi_clk_div - 1));

  always_ff @(posedge clk) begin
    if (start && !busy) shift_q <= word[dac_word_bits-2:0];
    else if (busy && !tail && half_done && sclk)
      shift_q <= {shift_q[dac_word_bits-3:0], 1'b0}; // next bit on falling edge
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy    <= 1'b0;
      cs_n    <= 1'b1;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      tail    <= 1'b0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        cs_n    <= 1'b0;                   // cs falls the cycle after start
        mosi    <= word[dac_word_bits-1];  // msb set up before first rise
        div_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (tail) begin
      // one hold cycle with cs low, then cs high for one cycle under busy
      if (!cs_n) begin
        cs_n <= 1'b1;
      end else begin
        busy <= 1'b0;
        tail <= 1'b0;
      end
    end else if (half_done) begin
      div_cnt <= '0;
      sclk    <= ~sclk;
      if (sclk) begin // falling edge
        if (bit_cnt == bit_w'(dac_word_bits - 1)) begin
          tail <= 1'b1; // 24th bit done
          mosi <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          mosi    <= shift_q[dac_word_bits-2];
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

/* design/mems_pattern_rom.sv */
`timescale 1ns/100ps

module mems_pattern_rom (
  input  logic                                     clk,
  input  logic [mems_scan_pkg::scan_addr_bits-1:0] addr,
  output logic [mems_scan_pkg::rom_entry_bits-1:0] entry
);
  import mems_scan_pkg::*;

  localparam int depth = 32;

  logic [rom_entry_bits-1:0] mem [0:depth-1]; // {channel, sample}

  // pattern is fixed at build time
  initial begin
    $readmemh("mems_pattern.mem", mem);
  end

  // registered read, one cycle behind addr
  always_ff @(posedge clk) begin
    entry <= mem[addr[4:0]]; // only low 5 bits index 32 entries
  end

endmodule

/* design/mems_scan_fsm.sv */
`timescale 1ns/100ps

module mems_scan_fsm (
  input  logic                                     clk,
  input  logic                                     mems_soft_reset,
  input  logic                                     pause,
  scan_ctrl_if.fsm                                 ctrl,
  input  logic [mems_scan_pkg::rom_entry_bits-1:0] rom_entry,
  input  logic                                     spi_busy,
  output logic                                     spi_start,
  output mems_scan_pkg::dac_word_u                 spi_word,
  output logic                                     mark_line,
  output logic                                     mark_frame
);
  import mems_scan_pkg::*;

  localparam logic [1:0] st_idle       = 2'd0;
  localparam logic [1:0] st_sw_reset   = 2'd1; // reset cmd in flight
  localparam logic [1:0] st_vref_setup = 2'd2; // ref cmd in flight
  localparam logic [1:0] st_scan       = 2'd3;

  logic [1:0] state;
  logic       issue_ok; // master idle and no start last cycle

  assign issue_ok = !spi_busy && !spi_start;

  assign ctrl.clear = (state == st_idle);                      // park counter at scan_first
  assign ctrl.step  = (state == st_scan) && issue_ok && !pause; // pause holds between frames

  // marks go out with the step, flags latch on the same edge
  assign mark_line  = ctrl.step && ctrl.line_end;
  assign mark_frame = ctrl.step && ctrl.frame_end;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state     <= st_idle;
      spi_start <= 1'b0;
    end else begin
      spi_start <= 1'b0; // single cycle pulse
      case (state)
        st_idle: begin
          spi_start <= 1'b1; // first cycle out of reset
          state     <= st_sw_reset;
        end
        st_sw_reset: begin
          if (issue_ok) begin
            spi_start <= 1'b1;
            state     <= st_vref_setup;
          end
        end
        st_vref_setup: begin
          if (issue_ok) state <= st_scan; // ref frame done
        end
        default: begin
          if (ctrl.step) spi_start <= 1'b1;
        end
      endcase
    end
  end

  // command word, held until the master latches it
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      spi_word.ctrl <= '{pad: 2'b00, cmd: dac_cmd_sw_reset, addr: 3'b000,
                         rsvd: '0, ctl: dac_reset_mode_por};
    end else if (state == st_sw_reset && issue_ok) begin
      spi_word.ctrl <= '{pad: 2'b00, cmd: dac_cmd_ref_setup, addr: 3'b000,
                         rsvd: '0, ctl: dac_ref_internal};
    end else if (ctrl.step) begin
      // rom entry already reflects the current addr
      spi_word.chan <= '{pad: 2'b00, cmd: dac_cmd_write_update,
                         addr: {1'b0, rom_entry[17:16]}, value: rom_entry[15:0]};
    end
  end

  // back to back frames never overlap in the master
  assert property (@(posedge clk) disable iff (mems_soft_reset)
    spi_start |-> !spi_busy);

  // each step launches a channel write, never a setup word
  assert property (@(posedge clk) disable iff (mems_soft_reset)
    ctrl.step |=> spi_start && (spi_word.chan.cmd == dac_cmd_write_update));

endmodule

/* design/mems_scan_pkg.sv */
package mems_scan_pkg;

  // frame and pattern widths
  localparam int dac_word_bits  = 24; // one spi frame to the dac
  localparam int rom_entry_bits = 18; // 2b channel + 16b sample
  localparam int scan_addr_bits = 16;

  // dac command field, bits 21:19 of the frame
  localparam logic [2:0] dac_cmd_write_update = 3'b011; // write input reg and update output
  localparam logic [2:0] dac_cmd_sw_reset     = 3'b101;
  localparam logic [2:0] dac_cmd_ref_setup    = 3'b111; // internal reference on/off

  // control bit values for the two setup commands
  localparam logic dac_reset_mode_por = 1'b1; // full reset, incl. power-down regs
  localparam logic dac_ref_internal   = 1'b1; // internal reference on

  // one dac frame, low 16 bits depend on the command
  typedef union packed {
    struct packed {
      logic [1:0]  pad;   // don't care on the wire
      logic [2:0]  cmd;
      logic [2:0]  addr;  // channel a..d
      logic [15:0] value; // dac code
    } chan;
    struct packed {
      logic [1:0]  pad;
      logic [2:0]  cmd;
      logic [2:0]  addr;  // ignored by the dac for setup cmds
      logic [14:0] rsvd;
      logic        ctl;   // reset mode or ref enable
    } ctrl;
  } dac_word_u;

endpackage

/* design/mems_scan_top.sv */
`timescale 1ns/100ps

module mems_scan_top #(
  parameter logic [mems_scan_pkg::scan_addr_bits-1:0] scan_first      = 16'd8,
  parameter logic [mems_scan_pkg::scan_addr_bits-1:0] scan_last       = 16'd31,
  parameter int                                       line_len        = 4,
  parameter int                                       lines_per_frame = 3,
  parameter int                                       spi_clk_div     = 2
) (
  input  logic clk,
  input  logic mems_soft_reset,
  input  logic pause,
  input  logic new_line_fifo_done,
  input  logic new_frame_fifo_done,
  output logic spi_sclk,
  output logic spi_mosi,
  output logic spi_cs_n,
  output logic new_line,
  output logic new_frame
);
  import mems_scan_pkg::*;

  logic [rom_entry_bits-1:0] rom_entry;
  logic                      spi_start;
  logic                      spi_busy;
  dac_word_u                 spi_word;
  logic                      mark_line;
  logic                      mark_frame;

  scan_ctrl_if u_scan_ctrl_if ();

  mems_scan_fsm u_mems_scan_fsm (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .pause           (pause),
    .ctrl            (u_scan_ctrl_if.fsm),
    .rom_entry       (rom_entry),
    .spi_busy        (spi_busy),
    .spi_start       (spi_start),
    .spi_word        (spi_word),
    .mark_line       (mark_line),
    .mark_frame      (mark_frame)
  );

  scan_addr_counter #(
    .scan_first      (scan_first),
    .scan_last       (scan_last),
    .line_len        (line_len),
    .lines_per_frame (lines_per_frame)
  ) u_scan_addr_counter (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .ctrl            (u_scan_ctrl_if.counter)
  );

  mems_pattern_rom u_mems_pattern_rom (
    .clk   (clk),
    .addr  (u_scan_ctrl_if.addr), // rom follows the counter directly
    .entry (rom_entry)
  );

  dac_spi_master #(
    .spi_clk_div (spi_clk_div)
  ) u_dac_spi_master (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (spi_start),
    .word            (spi_word),
    .busy            (spi_busy),
    .sclk            (spi_sclk),
    .mosi            (spi_mosi),
    .cs_n            (spi_cs_n)
  );

  scan_marker_flags u_scan_marker_flags (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .mark_line       (mark_line),
    .mark_frame      (mark_frame),
    .line_done       (new_line_fifo_done),
    .frame_done      (new_frame_fifo_done),
    .new_line        (new_line),
    .new_frame       (new_frame)
  );

endmodule

/* design/scan_addr_counter.sv */
`timescale 1ns/100ps

module scan_addr_counter #(
  parameter logic [mems_scan_pkg::scan_addr_bits-1:0] scan_first      = 16'd8,
  parameter logic [mems_scan_pkg::scan_addr_bits-1:0] scan_last       = 16'd31,
  parameter int                                       line_len        = 4,
  parameter int                                       lines_per_frame = 3
) (
  input  logic         clk,
  input  logic         mems_soft_reset,
  scan_ctrl_if.counter ctrl
);
  import mems_scan_pkg::*;

  localparam int pos_w  = (line_len > 1) ? $clog2(line_len) : 1;
  localparam int line_w = (lines_per_frame > 1) ? $clog2(lines_per_frame) : 1;

  logic [scan_addr_bits-1:0] addr;
  logic [pos_w-1:0]          pos;      // sample within line
  logic [line_w-1:0]         line_idx; // line within frame

  assign ctrl.addr      = addr;
  assign ctrl.line_end  = (pos == pos_w'(line_len - 1));
  assign ctrl.frame_end = ctrl.line_end && (line_idx == line_w'(lines_per_frame - 1));

  always_ff @(posedge clk) begin
    if (mems_soft_reset || ctrl.clear) begin
      addr     <= scan_first;
      pos      <= '0;
      line_idx <= '0;
    end else if (ctrl.step) begin
      if (addr == scan_last) begin
        // wrap restarts line and frame tracking too
        addr     <= scan_first;
        pos      <= '0;
        line_idx <= '0;
      end else begin
        addr <= addr + 1'b1;
        if (ctrl.line_end) begin
          pos <= '0;
          if (ctrl.frame_end) line_idx <= '0; // next frame
          else line_idx <= line_idx + 1'b1;
        end else begin
          pos <= pos + 1'b1;
        end
      end
    end
  end

  // rom index never leaves the scan window, across wrap and clear
  assert property (@(posedge clk) disable iff (mems_soft_reset)
    (addr >= scan_first) && (addr <= scan_last));

endmodule

/* design/scan_ctrl_if.sv */
`timescale 1ns/100ps

interface scan_ctrl_if;
  import mems_scan_pkg::*;

  logic                      clear;     // reload scan_first
  logic                      step;      // advance one command
  logic [scan_addr_bits-1:0] addr;      // current scan address
  logic                      line_end;  // addr closes a line
  logic                      frame_end; // addr closes a frame

  // fsm only drives the handshake, it never needs addr itself
  modport fsm (
    output clear, step,
    input  line_end, frame_end
  );

  modport counter (
    input  clear, step,
    output addr, line_end, frame_end
  );

endinterface

/* design/scan_marker_flags.sv */
`timescale 1ns/100ps

module scan_marker_flags (
  input  logic clk,
  input  logic mems_soft_reset,
  input  logic mark_line,
  input  logic mark_frame,
  input  logic line_done,  // pixel fifo took the line
  input  logic frame_done, // pixel fifo took the frame
  output logic new_line,
  output logic new_frame
);

  // sticky, set beats a same cycle clear
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      if (mark_line) new_line <= 1'b1;
      else if (line_done) new_line <= 1'b0;

      if (mark_frame) new_frame <= 1'b1;
      else if (frame_done) new_frame <= 1'b0;
    end
  end

  // frame end is always also a line end in the counter
  assert property (@(posedge clk) disable iff (mems_soft_reset)
    $rose(new_frame) |-> new_line);

endmodule

/* mems_pattern.mem */
// scan pattern rom, one 18-bit entry per line, address 0 first
// bits 17:16 dac channel, bits 15:0 sample code
00000
10001
20002
30003
08004
18005
28006
38007
01008
05009
0900A
1200B
0D00C
0900D
0500E
1400F
01010
05011
09012
16013
0D014
09015
05016
18017
01018
05019
0901A
1A01B
27F1C
37F1D
2801E
3801F

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mems scan testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
  -f sim.f --top-module tb_mems_scan -o tb_mems_scan > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mems_scan > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
exit 1

/* sim.f */
design/mems_scan_pkg.sv
design/scan_ctrl_if.sv
design/mems_scan_fsm.sv
design/scan_addr_counter.sv
design/mems_pattern_rom.sv
design/dac_spi_master.sv
design/scan_marker_flags.sv
design/mems_scan_top.sv
tb/dac_frame_monitor.sv
tb/tb_mems_scan.sv

/* tb/dac_frame_monitor.sv */
`timescale 1ns/100ps

module dac_frame_monitor (
  input logic clk,
  input logic sclk,
  input logic mosi,
  input logic cs_n
);
  import mems_scan_pkg::*;

  dac_word_u                frames[$];      // complete frames, oldest first
  int                       fall_cnt = 0;   // cs falling edges seen
  int                       bit_cnt  = 0;   // bits in the open frame
  logic [dac_word_bits-1:0] shift_word = '0;
  logic                     sclk_q = 1'b0;
  logic                     cs_n_q = 1'b1;

  // sclk and cs are sampled on clk, both come from clk flops in the dut
  always @(posedge clk) begin
    if (!cs_n && cs_n_q) begin
      fall_cnt = fall_cnt + 1; // frame opens
      bit_cnt  = 0;
    end
    if (!cs_n && sclk && !sclk_q) begin
      // dac side samples on the rising sclk
      shift_word = {shift_word[dac_word_bits-2:0], mosi};
      bit_cnt    = bit_cnt + 1;
    end
    if (cs_n && !cs_n_q) begin
      // a frame cut short by reset never reaches the queue
      if (bit_cnt == dac_word_bits) frames.push_back(shift_word);
      bit_cnt = 0;
    end
    sclk_q = sclk;
    cs_n_q = cs_n;
  end

endmodule

/* tb/tb_mems_scan.sv */
`timescale 1ns/100ps

module tb_mems_scan;
  import mems_scan_pkg::*;

  // mirrors the values mems_scan_top sets
  localparam int scan_first      = 8;
  localparam int scan_last       = 31;
  localparam int line_len        = 4;
  localparam int lines_per_frame = 3;
  localparam int timeout_cycles  = 60 * (48 * 2 + 6); // 60 frames, each with margin

  logic clk = 1'b0;
  logic mems_soft_reset;
  logic pause;
  logic new_line_fifo_done;
  logic new_frame_fifo_done;
  logic spi_sclk;
  logic spi_mosi;
  logic spi_cs_n;
  logic new_line;
  logic new_frame;

  logic [rom_entry_bits-1:0] pattern [0:31]; // rom image for predictions
  int   checks = 0;
  int   errors = 0;
  int   cycles = 0;
  logic line_exp;  // predicted new_line
  logic frame_exp; // predicted new_frame
  int   act_l;     // clear pending for the next step, 0 none 1 same edge 2 late
  int   act_f;

  always #2 clk = ~clk; // 4 ns period

  mems_scan_top u_mems_scan_top (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .pause               (pause),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .spi_sclk            (spi_sclk),
    .spi_mosi            (spi_mosi),
    .spi_cs_n            (spi_cs_n),
    .new_line            (new_line),
    .new_frame           (new_frame)
  );

  dac_frame_monitor u_dac_frame_monitor (
    .clk  (clk),
    .sclk (spi_sclk),
    .mosi (spi_mosi),
    .cs_n (spi_cs_n)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input dac_word_u got, input dac_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic dac_word_u setup_word(input logic [2:0] cmd, input logic ctl);
    dac_word_u w;
    w          = '0;
    w.ctrl.cmd = cmd;
    w.ctrl.ctl = ctl; // reset mode or ref enable
    return w;
  endfunction

  // one channel write per rom entry, {channel, sample}
  function automatic dac_word_u chan_word(input int a);
    dac_word_u w;
    w            = '0;
    w.chan.cmd   = dac_cmd_write_update;
    w.chan.addr  = {1'b0, pattern[a][17:16]};
    w.chan.value = pattern[a][15:0];
    return w;
  endfunction

  function automatic logic is_line_end(input int a);
    return ((a - scan_first) % line_len) == line_len - 1;
  endfunction

  function automatic logic is_frame_end(input int a);
    return ((a - scan_first) % (line_len * lines_per_frame)) == line_len * lines_per_frame - 1;
  endfunction

  // sticky flag after one step, set beats a clear on the same edge
  function automatic logic flag_model(input logic cur, input logic mark, input int act);
    case (act)
      0:       return cur | mark;
      1:       return mark;
      default: return 1'b0; // clear lands after the set
    endcase
  endfunction

  task automatic next_frame(output dac_word_u w);
    while (u_dac_frame_monitor.frames.size() == 0) begin
      @(posedge clk);
      #1;
    end
    w = u_dac_frame_monitor.frames.pop_front();
  endtask

  task automatic expect_scan(input int a);
    dac_word_u got;
    next_frame(got);
    check_word($sformatf("spi_mosi frame for addr %0d", a), got, chan_word(a));
  endtask

  // called right after a frame ends, so the next edge is the next step
  task automatic apply_done(input int l, input int f);
    int d;
    d                   = 4 + $urandom % 30; // still inside the next frame
    new_line_fifo_done  = (l == 1);
    new_frame_fifo_done = (f == 1);
    @(posedge clk);
    #1;
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
    repeat (d) @(posedge clk);
    #1;
    new_line_fifo_done  = (l == 2);
    new_frame_fifo_done = (f == 2);
    @(posedge clk);
    #1;
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
  endtask

  task automatic marked_frame(input int a, input int l, input int f);
    line_exp  = flag_model(line_exp, is_line_end(a), act_l);
    frame_exp = flag_model(frame_exp, is_frame_end(a), act_f);
    expect_scan(a);
    check_flag($sformatf("new_line after addr %0d", a), new_line, line_exp);
    check_flag($sformatf("new_frame after addr %0d", a), new_frame, frame_exp);
    act_l = l;
    act_f = f;
    apply_done(l, f);
  endtask

  task automatic setup_frames();
    dac_word_u got;
    next_frame(got);
    check_word("spi_mosi frame 1", got, setup_word(dac_cmd_sw_reset, dac_reset_mode_por));
    next_frame(got);
    check_word("spi_mosi frame 2", got, setup_word(dac_cmd_ref_setup, 1'b1));
    check_flag("new_line", new_line, 1'b0);
    check_flag("new_frame", new_frame, 1'b0);
    line_exp  = 1'b0;
    frame_exp = 1'b0;
    act_l     = 0;
    act_f     = 0;
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic setup_sequence();
    int err0;
    err0 = errors;
    setup_frames();
    report_test("setup_sequence", err0);
  endtask

  // every clear hits the next step edge, so flags show exactly the marks
  task automatic scan_first_pass();
    int err0;
    int a;
    err0 = errors;
    for (a = scan_first; a <= scan_last; a++) marked_frame(a, 1, 1);
    report_test("scan_first_pass", err0);
  endtask

  task automatic wrap_and_markers();
    int err0;
    int a;
    err0 = errors;
    for (a = scan_first; a < scan_first + 13; a++) begin
      if (a == scan_first + 11) marked_frame(a, 0, 0); // no done, both flags must hold
      else marked_frame(a, $urandom % 3, $urandom % 3);
    end
    report_test("wrap_and_markers", err0);
  endtask

  task automatic pause_hold();
    int err0;
    int falls;
    err0  = errors;
    pause = 1'b1; // frame for addr 21 already in flight
    expect_scan(scan_first + 13);
    falls = u_dac_frame_monitor.fall_cnt;
    repeat (150) @(posedge clk);
    #1;
    checks++;
    if (u_dac_frame_monitor.fall_cnt != falls) begin
      errors++;
      $display("pause: a new spi frame started while pause was high");
    end
    check_flag("spi_cs_n", spi_cs_n, 1'b1);
    pause = 1'b0;
    expect_scan(scan_first + 14);
    expect_scan(scan_first + 15);
    report_test("pause_hold", err0);
  endtask

  task automatic reset_restart();
    int err0;
    err0 = errors;
    repeat (20) @(posedge clk); // mid frame
    #1;
    mems_soft_reset = 1'b1;
    @(posedge clk);
    #1;
    check_flag("spi_cs_n", spi_cs_n, 1'b1);
    check_flag("spi_sclk", spi_sclk, 1'b0);
    check_flag("new_line", new_line, 1'b0);
    check_flag("new_frame", new_frame, 1'b0);
    repeat (4) @(posedge clk);
    #1;
    mems_soft_reset = 1'b0;
    setup_frames();
    expect_scan(scan_first);
    expect_scan(scan_first + 1);
    report_test("reset_restart", err0);
  endtask

  initial begin
    mems_soft_reset     = 1'b1;
    pause               = 1'b0;
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
    void'($urandom(18693));
    $readmemh("mems_pattern.mem", pattern);
    repeat (5) @(posedge clk);
    #1;
    mems_soft_reset = 1'b0;
    setup_sequence();
    scan_first_pass();
    wrap_and_markers();
    pause_hold();
    reset_restart();
    $display("summary: %0d compares, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
